//--- hw/l2_mem.sv
// ##########################################################
// L2 word memory
// ##########################################################

`timescale 1ns/100ps

module l2_mem import soc_pkg::*; #(
  parameter int unsigned  L2_WORDS = 256,
  localparam int unsigned IDX_W    = $clog2(L2_WORDS)
) (
  input  logic             clk_i,
  input  logic             en_i,
  input  logic             we_i,
  input  logic [IDX_W-1:0] idx_i,
  input  data_t            wdata_i,
  output data_t            rdata_o
);

  data_t mem_q [L2_WORDS];

  // single port, write or read per enabled cycle
  always_ff @(posedge clk_i) begin
    if (en_i) begin
      if (we_i) begin
        mem_q[idx_i] <= wdata_i;
      end else begin
        // read data valid one edge after the enable
        rdata_o <= mem_q[idx_i];
      end
    end
  end

endmodule

//--- hw/soc_bus.sv
// ##########################################################
// SoC bus, round-robin to L2
// ##########################################################

`timescale 1ns/100ps

module soc_bus import soc_pkg::*; #(
  parameter int unsigned N_MST    = 3,
  parameter int unsigned L2_WORDS = 256,
  localparam int unsigned IDX_W   = $clog2(L2_WORDS)
) (
  input  logic                clk_i,
  input  logic                rst_n_i,

  // request channels, one per master
  input  logic  [N_MST-1:0]   req_valid_i,
  output logic  [N_MST-1:0]   req_ready_o,
  input  logic  [N_MST-1:0]   req_we_i,
  input  addr_t [N_MST-1:0]   req_addr_i,
  input  data_t [N_MST-1:0]   req_wdata_i,

  // response, valid per master, payload shared
  output logic  [N_MST-1:0]   rsp_valid_o,
  output data_t               rsp_rdata_o,
  output logic                rsp_err_o,

  // L2 memory port
  output logic                mem_en_o,
  output logic                mem_we_o,
  output logic  [IDX_W-1:0]   mem_idx_o,
  output data_t               mem_wdata_o,
  input  data_t               mem_rdata_i
);

  localparam int unsigned MST_W    = (N_MST > 1) ? $clog2(N_MST) : 1;
  localparam addr_t       L2_LIMIT = addr_t'(L2_WORDS * 4);

  // round-robin candidate at offset off from base, wrapping at N_MST
  function automatic logic [MST_W-1:0] rr_index(input logic [MST_W-1:0] base,
                                                input int unsigned     off);
    int unsigned sel;
    sel = int'(base) + off;
    if (sel >= N_MST) begin
      sel = sel - N_MST;
    end
    return MST_W'(sel);
  endfunction

  logic [MST_W-1:0] rr_ptr_q;
  logic [MST_W-1:0] grant_idx;
  logic [MST_W-1:0] next_ptr;
  logic             grant_found;
  addr_t            grant_addr;
  logic             addr_ok;

  // response stage
  logic             rsp_pend_q;
  logic [MST_W-1:0] rsp_mst_q;
  logic             rsp_err_q;

  // first valid master starting from the priority pointer
  always_comb begin
    grant_found = 1'b0;
    grant_idx   = '0;
    for (int unsigned k = 0; k < N_MST; k++) begin
      if (!grant_found && req_valid_i[rr_index(rr_ptr_q, k)]) begin
        grant_found = 1'b1;
        grant_idx   = rr_index(rr_ptr_q, k);
      end
    end
  end

  always_comb begin
    for (int unsigned i = 0; i < N_MST; i++) begin
      req_ready_o[i] = grant_found && (grant_idx == MST_W'(i));
      rsp_valid_o[i] = rsp_pend_q && (rsp_mst_q == MST_W'(i));
    end
  end

  assign next_ptr = (grant_idx == MST_W'(N_MST - 1)) ? '0 : grant_idx + 1'b1;

  // range and word alignment check on the winner
  assign grant_addr = req_addr_i[grant_idx];
  assign addr_ok    = (grant_addr < L2_LIMIT) && (grant_addr[1:0] == 2'b00);

  // failing requests never reach the memory
  assign mem_en_o    = grant_found && addr_ok;
  assign mem_we_o    = req_we_i[grant_idx];
  assign mem_idx_o   = grant_addr[IDX_W+1:2];
  assign mem_wdata_o = req_wdata_i[grant_idx];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rr_ptr_q   <= '0;
      rsp_pend_q <= 1'b0;
      rsp_mst_q  <= '0;
      rsp_err_q  <= 1'b0;
    end else begin
      rsp_pend_q <= grant_found;
      if (grant_found) begin
        rr_ptr_q  <= next_ptr;
        rsp_mst_q <= grant_idx;
        rsp_err_q <= !addr_ok;
      end
    end
  end

  // read data lines up with the registered response
  assign rsp_rdata_o = rsp_err_q ? '0 : mem_rdata_i;
  assign rsp_err_o   = rsp_err_q;

endmodule

//--- hw/soc_cluster.sv
// ##########################################################
// Compute cluster, sums its L2 region
// ##########################################################

`timescale 1ns/100ps

module soc_cluster import soc_pkg::*; #(
  parameter int unsigned CLUSTER_ID = 0,
  parameter int unsigned JOB_LEN    = 8
) (
  input  logic      clk_i,
  input  logic      rst_n_i,

  // cluster control
  input  logic      fetch_en_i,
  output logic      eoc_o,
  output logic      busy_o,

  // request channel to the SoC bus
  output logic      req_valid_o,
  input  logic      req_ready_i,
  output logic      req_we_o,
  output addr_t     req_addr_o,
  output data_t     req_wdata_o,

  // response channel, always accepted
  input  logic      rsp_valid_i,
  input  data_t     rsp_rdata_i
);

  // counter runs 0..JOB_LEN, the last value selects the result word
  localparam int unsigned CNT_W = $clog2(JOB_LEN + 1);

  // region starts at word CLUSTER_ID*(JOB_LEN+1)
  localparam addr_t BASE_ADDR = addr_t'(CLUSTER_ID * (JOB_LEN + 1) * 4);

  cl_state_e        state_q;
  logic [CNT_W-1:0] cnt_q;
  data_t            sum_q;
  logic             wr_phase;

  // all reads done once the counter reaches JOB_LEN
  assign wr_phase = (cnt_q == CNT_W'(JOB_LEN));

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= CL_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        CL_IDLE: begin
          if (fetch_en_i) begin
            state_q <= CL_READ;
            cnt_q   <= '0;
          end
        end
        CL_READ: begin
          if (req_ready_i) begin
            state_q <= CL_WAIT;
          end
        end
        CL_WAIT: begin
          if (rsp_valid_i) begin
            if (wr_phase) begin
              // response to the result write
              state_q <= CL_DONE;
            end else begin
              cnt_q   <= cnt_q + 1'b1;
              state_q <= (cnt_q == CNT_W'(JOB_LEN - 1)) ? CL_WRITE : CL_READ;
            end
          end
        end
        CL_WRITE: begin
          if (req_ready_i) begin
            state_q <= CL_WAIT;
          end
        end
        CL_DONE: begin
          if (!fetch_en_i) begin
            state_q <= CL_IDLE;
          end
        end
        default: state_q <= CL_IDLE;
      endcase
    end
  end

  // running sum, cleared while idle
  always_ff @(posedge clk_i) begin
    if (state_q == CL_IDLE) begin
      sum_q <= '0;
    end else if (state_q == CL_WAIT && rsp_valid_i && !wr_phase) begin
      sum_q <= sum_q + rsp_rdata_i;
    end
  end

  // request fields only change outside READ and WRITE
  assign req_valid_o = (state_q == CL_READ) || (state_q == CL_WRITE);
  assign req_we_o    = (state_q == CL_WRITE);
  assign req_addr_o  = BASE_ADDR + (addr_t'(cnt_q) << 2);
  assign req_wdata_o = sum_q;

  assign busy_o = (state_q == CL_READ) || (state_q == CL_WAIT) || (state_q == CL_WRITE);
  assign eoc_o  = (state_q == CL_DONE);

endmodule

//--- hw/soc_pkg.sv
// ##########################################################
// SoC shared definitions
// ##########################################################

package soc_pkg;

  // byte address and data word widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  // byte address on the SoC bus
  typedef logic [ADDR_W-1:0] addr_t;

  // one L2 data word
  typedef logic [DATA_W-1:0] data_t;

  // cluster job sequencer
  //   CL_IDLE  : waiting for fetch enable
  //   CL_READ  : read request pending on the bus
  //   CL_WAIT  : waiting for a read or write response
  //   CL_WRITE : result write pending on the bus
  //   CL_DONE  : end of computation, held until fetch enable drops
  typedef enum logic [2:0] {
    CL_IDLE,
    CL_READ,
    CL_WAIT,
    CL_WRITE,
    CL_DONE
  } cl_state_e;

endpackage

//--- hw/soc_top.sv
// ##########################################################
// SoC top with clusters, bus and L2
// ##########################################################

`timescale 1ns/100ps

module soc_top import soc_pkg::*; #(
  parameter int unsigned N_CLUSTERS = 2,
  parameter int unsigned L2_WORDS   = 256,
  parameter int unsigned JOB_LEN    = 8
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,

  // cluster control
  input  logic [N_CLUSTERS-1:0] cl_fetch_en_i,
  output logic [N_CLUSTERS-1:0] cl_eoc_o,
  output logic [N_CLUSTERS-1:0] cl_busy_o,

  // host port into the SoC
  input  logic                  host_req_valid_i,
  output logic                  host_req_ready_o,
  input  logic                  host_req_we_i,
  input  addr_t                 host_req_addr_i,
  input  data_t                 host_req_wdata_i,
  output logic                  host_rsp_valid_o,
  output data_t                 host_rsp_rdata_o,
  output logic                  host_rsp_err_o
);

  // clusters first, host on the last master slot
  localparam int unsigned N_MST = N_CLUSTERS + 1;
  localparam int unsigned IDX_W = $clog2(L2_WORDS);

  logic  [N_MST-1:0] mst_req_valid;
  logic  [N_MST-1:0] mst_req_ready;
  logic  [N_MST-1:0] mst_req_we;
  addr_t [N_MST-1:0] mst_req_addr;
  data_t [N_MST-1:0] mst_req_wdata;
  logic  [N_MST-1:0] mst_rsp_valid;
  data_t             rsp_rdata;
  logic              rsp_err;

  logic              mem_en;
  logic              mem_we;
  logic [IDX_W-1:0]  mem_idx;
  data_t             mem_wdata;
  data_t             mem_rdata;

  for (genvar i = 0; i < N_CLUSTERS; i++) begin : gen_clusters
    soc_cluster #(
      .CLUSTER_ID (i),
      .JOB_LEN    (JOB_LEN)
    ) i_cluster (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .fetch_en_i  (cl_fetch_en_i[i]),
      .eoc_o       (cl_eoc_o[i]),
      .busy_o      (cl_busy_o[i]),
      .req_valid_o (mst_req_valid[i]),
      .req_ready_i (mst_req_ready[i]),
      .req_we_o    (mst_req_we[i]),
      .req_addr_o  (mst_req_addr[i]),
      .req_wdata_o (mst_req_wdata[i]),
      .rsp_valid_i (mst_rsp_valid[i]),
      .rsp_rdata_i (rsp_rdata)
    );
  end

  // host master
  assign mst_req_valid[N_CLUSTERS] = host_req_valid_i;
  assign mst_req_we[N_CLUSTERS]    = host_req_we_i;
  assign mst_req_addr[N_CLUSTERS]  = host_req_addr_i;
  assign mst_req_wdata[N_CLUSTERS] = host_req_wdata_i;
  assign host_req_ready_o          = mst_req_ready[N_CLUSTERS];
  assign host_rsp_valid_o          = mst_rsp_valid[N_CLUSTERS];
  assign host_rsp_rdata_o          = rsp_rdata;
  assign host_rsp_err_o            = rsp_err;

  soc_bus #(
    .N_MST    (N_MST),
    .L2_WORDS (L2_WORDS)
  ) i_soc_bus (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (mst_req_valid),
    .req_ready_o (mst_req_ready),
    .req_we_i    (mst_req_we),
    .req_addr_i  (mst_req_addr),
    .req_wdata_i (mst_req_wdata),
    .rsp_valid_o (mst_rsp_valid),
    .rsp_rdata_o (rsp_rdata),
    .rsp_err_o   (rsp_err),
    .mem_en_o    (mem_en),
    .mem_we_o    (mem_we),
    .mem_idx_o   (mem_idx),
    .mem_wdata_o (mem_wdata),
    .mem_rdata_i (mem_rdata)
  );

  l2_mem #(
    .L2_WORDS (L2_WORDS)
  ) i_l2_mem (
    .clk_i   (clk_i),
    .en_i    (mem_en),
    .we_i    (mem_we),
    .idx_i   (mem_idx),
    .wdata_i (mem_wdata),
    .rdata_o (mem_rdata)
  );

endmodule

//--- run_sim.sh
#!/bin/sh
# build the soc_top testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_soc_top \
  -f soc_top.f -Mdir obj_dir -o tb_soc_top \
  && ./obj_dir/tb_soc_top > sim.log 2>&1 \
  || echo "build or simulation stopped with an error"

cat sim.log 2>/dev/null
grep -q "RESULT: PASS" sim.log && exit 0 || exit 1

//--- sim/soc_top_sva.sv
// ##########################################################
// SoC top protocol assertions
// ##########################################################

`timescale 1ns/100ps

module soc_top_sva import soc_pkg::*; #(
  parameter int unsigned N_CLUSTERS = 2
) (
  input logic                  clk_i,
  input logic                  rst_n_i,
  input logic [N_CLUSTERS-1:0] cl_fetch_en_i,
  input logic [N_CLUSTERS-1:0] cl_eoc_i,
  input logic [N_CLUSTERS-1:0] cl_busy_i,
  // bus side of every master, host on the last slot
  input logic [N_CLUSTERS:0]   mst_req_valid_i,
  input logic [N_CLUSTERS:0]   mst_req_ready_i,
  input logic [N_CLUSTERS:0]   mst_req_we_i,
  input addr_t [N_CLUSTERS:0]  mst_req_addr_i,
  input data_t [N_CLUSTERS:0]  mst_req_wdata_i,
  input logic [N_CLUSTERS:0]   mst_rsp_valid_i
);

  // control and bus outputs quiet while in reset
  reset_quiet_a: assert property (@(posedge clk_i)
    !rst_n_i |-> (cl_busy_i == '0) && (cl_eoc_i == '0) &&
                 (mst_rsp_valid_i == '0) && (mst_req_ready_i == '0))
    else $error("busy, eoc, ready or response active during reset");

  for (genvar m = 0; m <= N_CLUSTERS; m++) begin : gen_mst
    // one response pulse on the edge after acceptance
    rsp_next_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      mst_req_valid_i[m] && mst_req_ready_i[m] |=> mst_rsp_valid_i[m])
      else $error("master %0d got no response one cycle after acceptance", m);

    // pending request held until ready
    req_stable_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      mst_req_valid_i[m] && !mst_req_ready_i[m] |=>
        mst_req_valid_i[m] && $stable(mst_req_we_i[m]) &&
        $stable(mst_req_addr_i[m]) && $stable(mst_req_wdata_i[m]))
      else $error("master %0d changed its request before ready", m);
  end

  for (genvar i = 0; i < N_CLUSTERS; i++) begin : gen_cl
    eoc_busy_a: assert property (@(posedge clk_i) !(cl_eoc_i[i] && cl_busy_i[i]))
      else $error("cluster %0d shows eoc and busy together", i);

    // idle cluster with fetch enable turns busy on the next edge
    busy_start_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      cl_fetch_en_i[i] && !cl_busy_i[i] && !cl_eoc_i[i] |=> cl_busy_i[i])
      else $error("cluster %0d did not turn busy after fetch enable", i);

    // eoc held as long as fetch enable stays high
    eoc_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      cl_eoc_i[i] && cl_fetch_en_i[i] |=> cl_eoc_i[i])
      else $error("cluster %0d dropped eoc while fetch enable was high", i);
  end

endmodule

bind soc_top soc_top_sva #(
  .N_CLUSTERS (N_CLUSTERS)
) i_soc_top_sva (
  .clk_i           (clk_i),
  .rst_n_i         (rst_n_i),
  .cl_fetch_en_i   (cl_fetch_en_i),
  .cl_eoc_i        (cl_eoc_o),
  .cl_busy_i       (cl_busy_o),
  .mst_req_valid_i (mst_req_valid),
  .mst_req_ready_i (mst_req_ready),
  .mst_req_we_i    (mst_req_we),
  .mst_req_addr_i  (mst_req_addr),
  .mst_req_wdata_i (mst_req_wdata),
  .mst_rsp_valid_i (mst_rsp_valid)
);

//--- sim/tb_soc_top.sv
// ##########################################################
// SoC top testbench
// ##########################################################

`timescale 1ns/100ps

module tb_soc_top import soc_pkg::*; ();

  localparam int unsigned N_CL        = 2;
  localparam int unsigned L2_WORDS    = 256;
  localparam int unsigned JOB_LEN     = 8;
  localparam int unsigned TIMEOUT     = 200;
  localparam int unsigned JOB_TIMEOUT = 2000;
  // host traffic during cluster jobs stays above this word
  localparam int unsigned HOST_BASE   = 64;

  logic            clk;
  logic            rst_n;
  logic [N_CL-1:0] fetch_en;
  logic [N_CL-1:0] eoc;
  logic [N_CL-1:0] busy;
  logic            req_valid;
  logic            req_ready;
  logic            req_we;
  addr_t           req_addr;
  data_t           req_wdata;
  logic            rsp_valid;
  data_t           rsp_rdata;
  logic            rsp_err;

  data_t           shadow [L2_WORDS];
  logic [31:0]     lcg_state;
  int unsigned     err_cnt;
  int unsigned     timeout_cnt;

  soc_top #(
    .N_CLUSTERS (N_CL),
    .L2_WORDS   (L2_WORDS),
    .JOB_LEN    (JOB_LEN)
  ) dut0 (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .cl_fetch_en_i    (fetch_en),
    .cl_eoc_o         (eoc),
    .cl_busy_o        (busy),
    .host_req_valid_i (req_valid),
    .host_req_ready_o (req_ready),
    .host_req_we_i    (req_we),
    .host_req_addr_i  (req_addr),
    .host_req_wdata_i (req_wdata),
    .host_rsp_valid_o (rsp_valid),
    .host_rsp_rdata_o (rsp_rdata),
    .host_rsp_err_o   (rsp_err)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // sum of a cluster region, wrapping at 32 bits
  function automatic data_t region_sum(input int unsigned cl);
    data_t sum;
    sum = '0;
    for (int unsigned k = 0; k < JOB_LEN; k++) begin
      sum = sum + shadow[cl * (JOB_LEN + 1) + k];
    end
    return sum;
  endfunction

  task automatic check_value(input string name, input data_t expected, input data_t actual);
    if (timeout_cnt == 0) begin
      assert (actual == expected)
      else begin
        $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
        err_cnt++;
      end
    end
  endtask

  // one host transfer, request held until ready, response sampled mid-cycle
  task automatic host_access(input logic we, input addr_t addr, input data_t wdata,
                             output data_t rdata, output logic err);
    int unsigned cnt;
    rdata = '0;
    err   = 1'b0;
    if (timeout_cnt != 0) return;
    @(posedge clk);
    req_valid <= 1'b1;
    req_we    <= we;
    req_addr  <= addr;
    req_wdata <= wdata;
    cnt = 0;
    @(negedge clk);
    while (!req_ready && cnt < TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (!req_ready) begin
      $display("host request to address %h was never accepted", addr);
      timeout_cnt++;
      return;
    end
    // transfer happens on this edge
    @(posedge clk);
    req_valid <= 1'b0;
    cnt = 0;
    @(negedge clk);
    while (!rsp_valid && cnt < TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (!rsp_valid) begin
      $display("no host response for address %h", addr);
      timeout_cnt++;
      return;
    end
    rdata = rsp_rdata;
    err   = rsp_err;
  endtask

  task automatic host_write(input int unsigned idx, input data_t data);
    data_t rdata;
    logic  err;
    host_access(1'b1, addr_t'(idx * 4), data, rdata, err);
    check_value("host write err", '0, data_t'(err));
    shadow[idx] = data;
  endtask

  task automatic host_read_check(input string name, input int unsigned idx);
    data_t rdata;
    logic  err;
    host_access(1'b0, addr_t'(idx * 4), '0, rdata, err);
    check_value(name, shadow[idx], rdata);
    check_value({name, " err"}, '0, data_t'(err));
  endtask

  task automatic host_expect_err(input string name, input logic we, input addr_t addr);
    data_t rdata;
    logic  err;
    host_access(we, addr, lcg_next(), rdata, err);
    check_value({name, " err"}, 32'd1, data_t'(err));
    check_value({name, " data"}, '0, rdata);
  endtask

  task automatic preload_region(input int unsigned cl);
    for (int unsigned k = 0; k < JOB_LEN; k++) begin
      host_write(cl * (JOB_LEN + 1) + k, lcg_next());
    end
  endtask

  task automatic wait_eoc(input logic [N_CL-1:0] mask, input logic level);
    int unsigned     cnt;
    logic [N_CL-1:0] want;
    cnt  = 0;
    want = level ? mask : '0;
    if (timeout_cnt != 0) return;
    @(negedge clk);
    while (((eoc & mask) != want) && cnt < JOB_TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if ((eoc & mask) != want) begin
      $display("cluster eoc did not reach %b within the timeout", want);
      timeout_cnt++;
    end
  endtask

  initial begin : main_seq
    int unsigned idx;
    int unsigned idx_q [$];
    lcg_state   = 32'h6300_55f1;
    err_cnt     = 0;
    timeout_cnt = 0;
    rst_n       = 1'b0;
    fetch_en    = '0;
    req_valid   = 1'b0;
    req_we      = 1'b0;
    req_addr    = '0;
    req_wdata   = '0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    // host round trip over random words
    host_write(0, lcg_next());
    for (int i = 0; i < 16; i++) begin
      idx = lcg_next() % L2_WORDS;
      host_write(idx, lcg_next());
      idx_q.push_back(idx);
    end
    foreach (idx_q[k]) begin
      host_read_check("host round trip", idx_q[k]);
    end

    // out of range and misaligned, the writes alias word 0
    host_expect_err("read beyond L2", 1'b0, addr_t'(L2_WORDS * 4 + 16));
    host_expect_err("write beyond L2", 1'b1, addr_t'(L2_WORDS * 4));
    host_expect_err("read top address", 1'b0, 32'hffff_fffc);
    host_expect_err("misaligned read", 1'b0, 32'd14);
    host_expect_err("misaligned write", 1'b1, 32'd2);
    host_read_check("word 0 after errors", 0);

    // single cluster job
    preload_region(0);
    @(posedge clk);
    fetch_en <= N_CL'(1);
    wait_eoc(N_CL'(1), 1'b1);
    shadow[JOB_LEN] = region_sum(0);
    host_read_check("cluster 0 result", JOB_LEN);
    @(posedge clk);
    fetch_en <= '0;
    wait_eoc(N_CL'(1), 1'b0);

    // all clusters with host traffic above the regions
    for (int unsigned c = 0; c < N_CL; c++) begin
      preload_region(c);
    end
    @(posedge clk);
    fetch_en <= '1;
    idx_q.delete();
    for (int i = 0; i < 12; i++) begin
      idx = HOST_BASE + lcg_next() % (L2_WORDS - HOST_BASE);
      host_write(idx, lcg_next());
      host_read_check("host during jobs", idx);
      idx_q.push_back(idx);
    end
    wait_eoc('1, 1'b1);
    for (int unsigned c = 0; c < N_CL; c++) begin
      shadow[c * (JOB_LEN + 1) + JOB_LEN] = region_sum(c);
      host_read_check("concurrent cluster result", c * (JOB_LEN + 1) + JOB_LEN);
    end
    @(posedge clk);
    fetch_en <= '0;
    wait_eoc('1, 1'b0);
    foreach (idx_q[k]) begin
      host_read_check("host data after jobs", idx_q[k]);
    end

    repeat (4) @(posedge clk);
    $display("errors: %0d check, %0d timeout", err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- soc_top.f
hw/soc_pkg.sv
hw/soc_cluster.sv
hw/soc_bus.sv
hw/l2_mem.sv
hw/soc_top.sv
sim/soc_top_sva.sv
sim/tb_soc_top.sv
